// ==== project.f ====
+incdir+hw
hw/pit_pkg.sv
hw/pit_bus_if.sv
hw/pit_tmr_if.sv
hw/pit_wb_slave.sv
hw/pit_regs.sv
hw/pit_counter.sv
hw/pit_top.sv
tb/pit_clkgen.sv
tb/pit_assert.sv
tb/pit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the timer testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="SIMULATION FAILED"
PASS_MSG="SIMULATION PASSED"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module pit_tb --Mdir "$BUILD_DIR" -o pit_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/pit_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
	exit 1
fi
if ! grep -q "$PASS_MSG" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0

// ==== tb/pit_tb.sv ====
`timescale 1ns/1ps
`include "pit_defs.svh"

module pit_tb;

	localparam int NUM_TESTS = 5;
	localparam int CYC_PER_TEST = 2000;
	localparam int ACK_LIMIT = 20;
	localparam int SEED = 62864;

	// control word bits
	localparam pit_pkg::dat_t F_LD = 1 << `PIT_CTL_LD;
	localparam pit_pkg::dat_t F_CE = 1 << `PIT_CTL_CE;
	localparam pit_pkg::dat_t F_AR = 1 << `PIT_CTL_AR;
	localparam pit_pkg::dat_t F_XC = 1 << `PIT_CTL_XC;
	localparam pit_pkg::dat_t F_GE = 1 << `PIT_CTL_GE;
	localparam pit_pkg::dat_t F_COMMIT = 1 << `PIT_CTL_COMMIT;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	pit_pkg::adr_t wb_adr;
	pit_pkg::dat_t wb_wdat;
	pit_pkg::sel_t wb_sel;
	pit_pkg::dat_t wb_rdat;
	logic wb_ack;
	logic [`PIT_NTIMER-1:0] ext_clk;
	logic [`PIT_NTIMER-1:0] gate;
	logic [`PIT_NTIMER-1:0] out_pins;
	logic irq;

	// reference model, holding and active state per channel
	pit_pkg::cnt_t m_max_h [0:`PIT_NTIMER-1];
	pit_pkg::cnt_t m_on_h [0:`PIT_NTIMER-1];
	pit_pkg::ctl_t m_ctl_h [0:`PIT_NTIMER-1];
	pit_pkg::cnt_t m_max_a [0:`PIT_NTIMER-1];
	pit_pkg::cnt_t m_on_a [0:`PIT_NTIMER-1];
	pit_pkg::ctl_t m_ctl_a [0:`PIT_NTIMER-1];
	pit_pkg::cnt_t m_count [0:`PIT_NTIMER-1];
	pit_pkg::tmask_t m_out;
	pit_pkg::tmask_t m_uf;
	pit_pkg::tmask_t m_ie;

	int err_cnt = 0;
	int chk_cnt = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cyc_cnt = 0;
	// edge index on which the last access was accepted
	int acc_cyc = 0;

	pit_clkgen clkgen_inst (
		.clk(clk),
		.rst(rst)
	);

	pit_top pit_top_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_wdat),
		.wb_sel_i(wb_sel),
		.wb_dat_o(wb_rdat),
		.wb_ack_o(wb_ack),
		.ext_clk_i(ext_clk),
		.gate_i(gate),
		.out_o(out_pins),
		.irq_o(irq)
	);

	always @(posedge clk)
		cyc_cnt <= cyc_cnt + 1;

	// ============================================================
	// compare tasks
	// ============================================================

	task automatic check_dat(input string name, input pit_pkg::dat_t exp,
		input pit_pkg::dat_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_cnt(input string name, input pit_pkg::cnt_t exp,
		input pit_pkg::cnt_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input pit_pkg::tmask_t exp,
		input pit_pkg::tmask_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// ============================================================
	// Wishbone master
	// ============================================================

	function automatic pit_pkg::adr_t reg_adr(input int ch, input int offs);
		return pit_pkg::adr_t'(ch * 4 + offs);
	endfunction

	// one classic cycle, entered and left 1 ns after a rising edge
	task automatic bus_access(input logic we, input pit_pkg::adr_t adr,
		input pit_pkg::dat_t wdat, input pit_pkg::sel_t sel, output pit_pkg::dat_t rdat);
		int n;
		n = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdat = wdat;
		wb_sel = sel;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!wb_ack && n < ACK_LIMIT);
		rdat = wb_rdat;
		acc_cyc = cyc_cnt;
		if (!wb_ack) begin
			err_cnt++;
			$display("no ack from the DUT for the access to word %h", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// stb stays low for one cycle after ack
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input pit_pkg::adr_t adr, input pit_pkg::dat_t d,
		input pit_pkg::sel_t sel);
		pit_pkg::dat_t unused;
		bus_access(1'b1, adr, d, sel, unused);
	endtask

	task automatic bus_read(input pit_pkg::adr_t adr, output pit_pkg::dat_t d);
		bus_access(1'b0, adr, '0, 4'hf, d);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// ============================================================
	// reference model
	// ============================================================

	function automatic pit_pkg::cnt_t lane_merge(input pit_pkg::cnt_t old_v,
		input pit_pkg::dat_t d, input pit_pkg::sel_t sel);
		pit_pkg::cnt_t m;
		m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_v & ~m) | (d & m);
	endfunction

	// holding to active, a pending load is applied at once
	task automatic commit_channel(input int ch);
		m_ctl_a[ch] = m_ctl_h[ch];
		m_max_a[ch] = m_max_h[ch];
		m_on_a[ch] = m_on_h[ch];
		if (m_ctl_a[ch][`PIT_CTL_LD]) begin
			m_count[ch] = m_max_a[ch];
			m_ctl_a[ch][`PIT_CTL_LD] = 1'b0;
		end
	endtask

	task automatic apply_write(input pit_pkg::adr_t adr, input pit_pkg::dat_t d,
		input pit_pkg::sel_t sel);
		int ch;
		ch = int'(adr[3:2]);
		if (adr < 8'h10) begin
			case (int'(adr[1:0]))
				1: m_max_h[ch] = lane_merge(m_max_h[ch], d, sel);
				2: m_on_h[ch] = lane_merge(m_on_h[ch], d, sel);
				3: begin
					if (sel[0]) begin
						m_ctl_h[ch] = d[4:0];
						if (d[`PIT_CTL_COMMIT])
							commit_channel(ch);
					end
				end
				default: ;
			endcase
		end else if (sel[0]) begin
			if (adr == `PIT_REG_UF) begin
				m_uf = m_uf & ~d[`PIT_NTIMER-1:0];
				m_ie = m_ie & ~d[`PIT_NTIMER-1:0];
			end else if (adr == `PIT_REG_IE) begin
				m_ie = d[`PIT_NTIMER-1:0];
			end else if (adr == `PIT_REG_SYNC) begin
				for (int i = 0; i < `PIT_NTIMER; i++)
					if (d[i])
						commit_channel(i);
			end
		end
	endtask

	task automatic write_reg(input pit_pkg::adr_t adr, input pit_pkg::dat_t d,
		input pit_pkg::sel_t sel);
		bus_write(adr, d, sel);
		apply_write(adr, d, sel);
	endtask

	// one qualified tick of a channel
	task automatic step_channel(input int ch);
		if (m_ctl_a[ch][`PIT_CTL_CE]) begin
			if (m_count[ch] == m_on_a[ch]) begin
				m_out[ch] = 1'b1;
				m_count[ch] = m_count[ch] - 1;
			end else if (m_count[ch] == 0) begin
				m_out[ch] = 1'b0;
				m_uf[ch] = 1'b1;
				if (m_ctl_a[ch][`PIT_CTL_AR])
					m_count[ch] = m_max_a[ch];
				else
					m_ctl_a[ch][`PIT_CTL_CE] = 1'b0;
			end else begin
				m_count[ch] = m_count[ch] - 1;
			end
		end
	endtask

	// legal pulses on one external clock pin, each at least 2 high and 2 low
	task automatic pulse_ext(input int ch, input int n);
		repeat (n) begin
			ext_clk[ch] = 1'b1;
			wait_cycles($urandom_range(2, 4));
			ext_clk[ch] = 1'b0;
			wait_cycles($urandom_range(2, 4));
			if (!m_ctl_a[ch][`PIT_CTL_GE] || gate[ch])
				step_channel(ch);
		end
	endtask

	function automatic pit_pkg::dat_t ctl_read(input int ch);
		return pit_pkg::dat_t'({m_ctl_a[ch][4:1], 1'b0});
	endfunction

	// ============================================================
	// tests
	// ============================================================

	task automatic test_readback();
		int ch;
		int kind;
		pit_pkg::adr_t adr;
		pit_pkg::dat_t d;
		pit_pkg::dat_t rd;
		pit_pkg::sel_t sel;
		for (int i = 0; i < 24; i++) begin
			ch = $urandom_range(0, `PIT_NTIMER - 1);
			kind = $urandom_range(1, 3);
			d = $urandom;
			sel = pit_pkg::sel_t'($urandom);
			// commit bit kept clear so active flags stay put
			d[`PIT_CTL_COMMIT] = 1'b0;
			adr = reg_adr(ch, kind);
			write_reg(adr, d, sel);
			bus_read(adr, rd);
			case (kind)
				1: check_dat($sformatf("max[%0d]", ch), m_max_h[ch], rd);
				2: check_dat($sformatf("on[%0d]", ch), m_on_h[ch], rd);
				default: check_dat($sformatf("ctl[%0d]", ch), ctl_read(ch), rd);
			endcase
		end
		write_reg(`PIT_REG_IE, $urandom, pit_pkg::sel_t'($urandom));
		bus_read(`PIT_REG_IE, rd);
		check_dat("ie", pit_pkg::dat_t'(m_ie), rd);
		bus_read(`PIT_REG_UF, rd);
		check_mask("uf", m_uf, rd[`PIT_NTIMER-1:0]);
		// unmapped words above the channels and above the globals
		bus_read(pit_pkg::adr_t'($urandom_range(8'h10, 8'h3f)), rd);
		check_dat("unmapped low", '0, rd);
		bus_read(pit_pkg::adr_t'($urandom_range(8'h44, 8'hff)), rd);
		check_dat("unmapped high", '0, rd);
	endtask

	task automatic test_load_stopped();
		int ch;
		pit_pkg::dat_t rd;
		ch = $urandom_range(0, `PIT_NTIMER - 1);
		write_reg(reg_adr(ch, `PIT_REG_MAX), $urandom, 4'hf);
		write_reg(reg_adr(ch, `PIT_REG_CTL), F_COMMIT | F_LD | F_AR, 4'hf);
		wait_cycles(3);
		bus_read(reg_adr(ch, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d]", ch), m_count[ch], rd);
		bus_read(reg_adr(ch, `PIT_REG_CTL), rd);
		check_dat($sformatf("ctl[%0d]", ch), ctl_read(ch), rd);
		// ce clear, count must hold
		wait_cycles($urandom_range(1, 60));
		bus_read(reg_adr(ch, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d] held", ch), m_count[ch], rd);
	endtask

	task automatic test_one_shot();
		int ch;
		int n;
		pit_pkg::cnt_t mx;
		pit_pkg::dat_t rd;
		ch = $urandom_range(0, `PIT_NTIMER - 1);
		mx = $urandom_range(3, 40);
		write_reg(`PIT_REG_IE, $urandom, 4'hf);
		write_reg(reg_adr(ch, `PIT_REG_MAX), mx, 4'hf);
		write_reg(reg_adr(ch, `PIT_REG_ON), $urandom_range(1, mx), 4'hf);
		write_reg(reg_adr(ch, `PIT_REG_CTL), F_COMMIT | F_LD | F_CE, 4'hf);
		// model runs to terminal count in one go
		while (m_ctl_a[ch][`PIT_CTL_CE])
			step_channel(ch);
		n = 0;
		do begin
			bus_read(reg_adr(ch, `PIT_REG_CTL), rd);
			n++;
		end while (rd[`PIT_CTL_CE] && n < 100);
		if (rd[`PIT_CTL_CE]) begin
			err_cnt++;
			$display("one-shot run on channel %0d never cleared its count enable", ch);
		end
		check_dat($sformatf("ctl[%0d]", ch), ctl_read(ch), rd);
		bus_read(reg_adr(ch, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d]", ch), m_count[ch], rd);
		bus_read(`PIT_REG_UF, rd);
		check_mask("uf", m_uf, rd[`PIT_NTIMER-1:0]);
		check_mask("out_o", m_out, out_pins);
		check_mask("irq_o", pit_pkg::tmask_t'(|(m_uf & m_ie)), pit_pkg::tmask_t'(irq));
		// clear this channel's flag and enable
		write_reg(`PIT_REG_UF, pit_pkg::dat_t'(1 << ch), 4'hf);
		bus_read(`PIT_REG_UF, rd);
		check_mask("uf after clear", m_uf, rd[`PIT_NTIMER-1:0]);
		bus_read(`PIT_REG_IE, rd);
		check_mask("ie after clear", m_ie, rd[`PIT_NTIMER-1:0]);
		check_mask("irq_o after clear", pit_pkg::tmask_t'(|(m_uf & m_ie)),
			pit_pkg::tmask_t'(irq));
	endtask

	task automatic test_ext_clock();
		int ch;
		pit_pkg::cnt_t mx;
		pit_pkg::dat_t rd;
		ch = $urandom_range(0, `PIT_NTIMER - 1);
		mx = $urandom_range(4, 12);
		write_reg(reg_adr(ch, `PIT_REG_MAX), mx, 4'hf);
		write_reg(reg_adr(ch, `PIT_REG_ON), $urandom_range(1, mx), 4'hf);
		write_reg(reg_adr(ch, `PIT_REG_CTL), F_COMMIT | F_LD | F_CE | F_AR | F_XC, 4'hf);
		wait_cycles(4);
		pulse_ext(ch, $urandom_range(10, 30));
		// last edge needs 3 clocks through the synchronizer
		wait_cycles(5);
		bus_read(reg_adr(ch, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d]", ch), m_count[ch], rd);
		check_mask("out_o", m_out, out_pins);
		bus_read(`PIT_REG_OUT, rd);
		check_mask("out reg", m_out, rd[`PIT_NTIMER-1:0]);
		bus_read(`PIT_REG_UF, rd);
		check_mask("uf", m_uf, rd[`PIT_NTIMER-1:0]);
		// gate enabled with the gate pin low blocks every pulse
		write_reg(reg_adr(ch, `PIT_REG_CTL), F_COMMIT | F_CE | F_AR | F_XC | F_GE, 4'hf);
		wait_cycles(3);
		pulse_ext(ch, $urandom_range(5, 15));
		wait_cycles(5);
		bus_read(reg_adr(ch, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d] gated", ch), m_count[ch], rd);
		check_mask("out_o gated", m_out, out_pins);
		write_reg(reg_adr(ch, `PIT_REG_CTL), F_COMMIT | F_AR, 4'hf);
		wait_cycles(2);
	endtask

	task automatic test_sync();
		int a;
		int b;
		int c;
		int t1;
		int n;
		pit_pkg::cnt_t mx;
		pit_pkg::dat_t mask;
		pit_pkg::dat_t rd;
		pit_pkg::dat_t rd_b;
		a = $urandom_range(0, `PIT_NTIMER - 1);
		b = (a + int'($urandom_range(1, `PIT_NTIMER - 1))) % `PIT_NTIMER;
		c = 0;
		while (c == a || c == b)
			c++;
		mask = pit_pkg::dat_t'((1 << a) | (1 << b));
		mx = $urandom_range(1000, 60000);
		// on above max never matches
		write_reg(reg_adr(a, `PIT_REG_MAX), mx, 4'hf);
		write_reg(reg_adr(b, `PIT_REG_MAX), mx, 4'hf);
		write_reg(reg_adr(a, `PIT_REG_ON), mx + 1, 4'hf);
		write_reg(reg_adr(b, `PIT_REG_ON), mx + 1, 4'hf);
		write_reg(reg_adr(a, `PIT_REG_CTL), F_LD | F_CE | F_AR, 4'hf);
		write_reg(reg_adr(b, `PIT_REG_CTL), F_LD | F_CE | F_AR, 4'hf);
		// holding flags of c differ from its active ones, a stray commit shows up
		write_reg(reg_adr(c, `PIT_REG_CTL), F_CE | F_AR, 4'hf);
		write_reg(`PIT_REG_SYNC, mask, 4'hf);
		t1 = acc_cyc;
		wait_cycles($urandom_range(5, 60));
		write_reg(reg_adr(a, `PIT_REG_CTL), F_AR, 4'hf);
		write_reg(reg_adr(b, `PIT_REG_CTL), F_AR, 4'hf);
		// second sync stops both on one edge
		bus_write(`PIT_REG_SYNC, mask, 4'hf);
		// commit, then load, then one tick per edge up to the stop
		n = acc_cyc - t1 - 2;
		repeat (n) begin
			step_channel(a);
			step_channel(b);
		end
		apply_write(`PIT_REG_SYNC, mask, 4'hf);
		wait_cycles(2);
		bus_read(reg_adr(a, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d]", a), m_count[a], rd);
		bus_read(reg_adr(b, `PIT_REG_COUNT), rd_b);
		check_cnt($sformatf("count[%0d]", b), m_count[b], rd_b);
		// channel left out of the sync
		bus_read(reg_adr(c, `PIT_REG_CTL), rd);
		check_dat($sformatf("ctl[%0d]", c), ctl_read(c), rd);
		bus_read(reg_adr(c, `PIT_REG_COUNT), rd);
		check_cnt($sformatf("count[%0d]", c), m_count[c], rd);
		check_mask("out_o", m_out, out_pins);
	endtask

	task automatic end_test(input int idx, input string name, input int err_before);
		int errs;
		errs = err_cnt - err_before;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: pass", idx, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail with %0d errors", idx, name, errs);
		end
	endtask

	// ============================================================
	// main sequence and watchdog
	// ============================================================

	initial begin
		int e0;
		void'($urandom(SEED));
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		wb_sel = '0;
		ext_clk = '0;
		gate = '0;
		// model reset state, ar set in both flag sets
		for (int i = 0; i < `PIT_NTIMER; i++) begin
			m_max_h[i] = '0;
			m_on_h[i] = '0;
			m_ctl_h[i] = pit_pkg::ctl_t'(F_AR);
			m_max_a[i] = '0;
			m_on_a[i] = '0;
			m_ctl_a[i] = pit_pkg::ctl_t'(F_AR);
			m_count[i] = '0;
		end
		m_out = '0;
		m_uf = '0;
		m_ie = '0;
		wait (rst === 1'b0);
		wait_cycles(1);

		e0 = err_cnt;
		test_readback();
		end_test(1, "register readback", e0);
		e0 = err_cnt;
		test_load_stopped();
		end_test(2, "load with count stopped", e0);
		e0 = err_cnt;
		test_one_shot();
		end_test(3, "one-shot and underflow clear", e0);
		e0 = err_cnt;
		test_ext_clock();
		end_test(4, "external clock and gate", e0);
		e0 = err_cnt;
		test_sync();
		end_test(5, "sync commit", e0);

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		repeat (NUM_TESTS * CYC_PER_TEST) @(posedge clk);
		$display("watchdog expired after %0d cycles before the tests finished",
			NUM_TESTS * CYC_PER_TEST);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== tb/pit_assert.sv ====
`timescale 1ns/1ps
`include "pit_defs.svh"

// bus handshake and pin checks on the top level
module pit_assert (
	input logic clk,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input pit_pkg::dat_t wb_dat_o,
	input logic [`PIT_NTIMER-1:0] out_o,
	input logic irq_o,
	input pit_pkg::tmask_t ie_i,
	input pit_pkg::tmask_t uf_i,
	input logic wr_i
);

	// ack is a single-cycle pulse
	ack_single: assert property (@(posedge clk) disable iff (rst)
		wb_ack_o |=> !wb_ack_o)
		else $error("ack held high for more than one cycle");

	// every ack answers a strobe seen on the edge before
	ack_after_stb: assert property (@(posedge clk) disable iff (rst)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else $error("ack without a preceding strobe");

	// an enabled underflow pulse raises the interrupt one edge later
	// unless a register write in that cycle touches the enables
	irq_after_uf: assert property (@(posedge clk) disable iff (rst)
		((uf_i & ie_i) != '0) && !wr_i |=> irq_o)
		else $error("irq_o not raised after an enabled underflow");

	// outputs known once reset is released
	no_unknown: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({wb_ack_o, wb_dat_o, out_o, irq_o}))
		else $error("unknown value on a top level output");

endmodule

bind pit_top pit_assert pit_assert_inst (
	.clk(clk),
	.rst(rst),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_ack_o(wb_ack_o),
	.wb_dat_o(wb_dat_o),
	.out_o(out_o),
	.irq_o(irq_o),
	.ie_i(regs_inst.ie),
	.uf_i(regs_inst.uf_v),
	.wr_i(regs_inst.wr)
);

// ==== tb/pit_clkgen.sv ====
`timescale 1ns/1ps

// free-running clock and power-on reset for the testbench
module pit_clkgen (
	output logic clk,
	output logic rst
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held over four rising edges, released just after the fourth
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// ==== hw/pit_top.sv ====
`timescale 1ns/1ps
`include "pit_defs.svh"

module pit_top (
	input logic clk,
	input logic rst,
	// Wishbone classic slave
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input pit_pkg::adr_t wb_adr_i,
	input pit_pkg::dat_t wb_dat_i,
	input pit_pkg::sel_t wb_sel_i,
	output pit_pkg::dat_t wb_dat_o,
	output logic wb_ack_o,
	// timer pins
	input logic [`PIT_NTIMER-1:0] ext_clk_i,
	input logic [`PIT_NTIMER-1:0] gate_i,
	output logic [`PIT_NTIMER-1:0] out_o,
	output logic irq_o
);

	pit_bus_if bus_if ();
	pit_tmr_if tmr_if [0:`PIT_NTIMER-1] ();

	// ============================================================
	// bus slave and register bank
	// ============================================================

	pit_wb_slave wb_slave_inst (
		.clk(clk),
		.rst(rst),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_sel_i(wb_sel_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.bus(bus_if)
	);

	pit_regs regs_inst (
		.clk(clk),
		.rst(rst),
		.bus(bus_if),
		.tmr(tmr_if),
		.irq_o(irq_o)
	);

	// ============================================================
	// counter channels
	// ============================================================

	for (genvar g = 0; g < `PIT_NTIMER; g++) begin : g_tmr
		pit_counter counter_inst (
			.clk(clk),
			.rst(rst),
			.ext_clk_i(ext_clk_i[g]),
			.gate_i(gate_i[g]),
			.tmr(tmr_if[g])
		);
		assign out_o[g] = tmr_if[g].out;
	end

endmodule

// ==== hw/pit_counter.sv ====
`timescale 1ns/1ps
`include "pit_defs.svh"

module pit_counter (
	input logic clk,
	input logic rst,
	input logic ext_clk_i,
	input logic gate_i,
	pit_tmr_if.timer tmr
);

	localparam pit_pkg::ctl_t CTL_RST = pit_pkg::ctl_t'(1 << `PIT_CTL_AR);

	// active state, loaded on commit
	pit_pkg::ctl_t ctl_a;
	pit_pkg::cnt_t max_a;
	pit_pkg::cnt_t on_a;
	pit_pkg::cnt_t count;
	logic out_q;
	logic uf_q;

	// external clock synchronizer and edge detect
	logic ext_s1;
	logic ext_s2;
	logic ext_d;
	logic ext_rise;

	logic src_ok;
	logic gate_ok;
	logic tick;

	// ============================================================
	// tick qualification
	// ============================================================

	assign ext_rise = ext_s2 & ~ext_d;
	// xc picks the external edge over the system clock
	assign src_ok = ctl_a[`PIT_CTL_XC] ? ext_rise : 1'b1;
	// ge makes counting wait for the gate pin
	assign gate_ok = ctl_a[`PIT_CTL_GE] ? gate_i : 1'b1;
	assign tick = ctl_a[`PIT_CTL_CE] & src_ok & gate_ok;

	always_ff @(posedge clk) begin
		if (rst) begin
			ext_s1 <= 1'b0;
			ext_s2 <= 1'b0;
			ext_d <= 1'b0;
		end else begin
			ext_s1 <= ext_clk_i;
			ext_s2 <= ext_s1;
			ext_d <= ext_s2;
		end
	end

	// ============================================================
	// count, reload and output
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ctl_a <= CTL_RST;
			max_a <= '0;
			on_a <= '0;
			count <= '0;
			out_q <= 1'b0;
			uf_q <= 1'b0;
		end else begin
			uf_q <= 1'b0;
			if (tmr.commit) begin
				ctl_a <= tmr.ctl_h;
				max_a <= tmr.max_h;
				on_a <= tmr.on_h;
			end else if (ctl_a[`PIT_CTL_LD]) begin
				// pending load overrides the tick
				count <= max_a;
				ctl_a[`PIT_CTL_LD] <= 1'b0;
			end else if (tick) begin
				if (count == on_a) begin
					out_q <= 1'b1;
					count <= count - 1'b1;
				end else if (count == '0) begin
					// terminal count
					uf_q <= 1'b1;
					out_q <= 1'b0;
					if (ctl_a[`PIT_CTL_AR])
						count <= max_a;
					else
						ctl_a[`PIT_CTL_CE] <= 1'b0;
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

	assign tmr.count = count;
	assign tmr.ctl_act = ctl_a;
	assign tmr.out = out_q;
	assign tmr.uf = uf_q;

endmodule

// ==== hw/pit_regs.sv ====
`timescale 1ns/1ps
`include "pit_defs.svh"

module pit_regs (
	input logic clk,
	input logic rst,
	pit_bus_if.regs bus,
	pit_tmr_if.regs tmr [0:`PIT_NTIMER-1],
	output logic irq_o
);

	// ar set, everything else clear
	localparam pit_pkg::ctl_t CTL_RST = pit_pkg::ctl_t'(1 << `PIT_CTL_AR);

	// holding registers per channel
	pit_pkg::cnt_t max_h [0:`PIT_NTIMER-1];
	pit_pkg::cnt_t on_h [0:`PIT_NTIMER-1];
	pit_pkg::ctl_t ctl_h [0:`PIT_NTIMER-1];

	// status gathered from the channels
	pit_pkg::cnt_t count_v [0:`PIT_NTIMER-1];
	pit_pkg::ctl_t ctl_act_v [0:`PIT_NTIMER-1];
	pit_pkg::tmask_t out_v;
	pit_pkg::tmask_t uf_v;

	pit_pkg::tmask_t commit_q;
	pit_pkg::tmask_t underflow;
	pit_pkg::tmask_t ie;
	pit_pkg::tmask_t uf_clr;

	logic wr;
	logic chan_hit;
	logic [1:0] chan;
	logic [1:0] offs;

	// merge the selected byte lanes of a write into a 32-bit value
	function automatic pit_pkg::cnt_t merge_bytes(
		input pit_pkg::cnt_t old_v,
		input pit_pkg::dat_t wd,
		input pit_pkg::sel_t sel
	);
		pit_pkg::cnt_t res;
		res = old_v;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[b*8 +: 8] = wd[b*8 +: 8];
		end
		return res;
	endfunction

	// ============================================================
	// address decode
	// ============================================================

	assign wr = bus.req && bus.we;
	// channel blocks occupy words 0..15
	assign chan_hit = (bus.adr[7:4] == 4'h0);
	assign chan = bus.adr[3:2];
	assign offs = bus.adr[1:0];

	// 1s written to UF clear flags and enables
	assign uf_clr = (wr && bus.adr == `PIT_REG_UF && bus.sel[0]) ?
		bus.wdat[`PIT_NTIMER-1:0] : '0;

	// ============================================================
	// channel links
	// ============================================================

	for (genvar g = 0; g < `PIT_NTIMER; g++) begin : g_link
		assign tmr[g].commit = commit_q[g];
		assign tmr[g].max_h = max_h[g];
		assign tmr[g].on_h = on_h[g];
		assign tmr[g].ctl_h = ctl_h[g];
		assign count_v[g] = tmr[g].count;
		assign ctl_act_v[g] = tmr[g].ctl_act;
		assign out_v[g] = tmr[g].out;
		assign uf_v[g] = tmr[g].uf;
	end

	// ============================================================
	// register writes
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PIT_NTIMER; i++) begin
				max_h[i] <= '0;
				on_h[i] <= '0;
				ctl_h[i] <= CTL_RST;
			end
			commit_q <= '0;
			underflow <= '0;
			ie <= '0;
		end else begin
			// commit is a single-cycle pulse
			commit_q <= '0;
			// a new terminal count wins over a clear in the same cycle
			underflow <= (underflow & ~uf_clr) | uf_v;
			ie <= ie & ~uf_clr;
			if (wr && bus.adr == `PIT_REG_IE && bus.sel[0])
				ie <= bus.wdat[`PIT_NTIMER-1:0];
			// sync register commits several channels on one edge
			if (wr && bus.adr == `PIT_REG_SYNC && bus.sel[0])
				commit_q <= bus.wdat[`PIT_NTIMER-1:0];
			for (int i = 0; i < `PIT_NTIMER; i++) begin
				if (wr && chan_hit && chan == 2'(i)) begin
					case (offs)
						`PIT_REG_MAX: max_h[i] <= merge_bytes(max_h[i], bus.wdat, bus.sel);
						`PIT_REG_ON: on_h[i] <= merge_bytes(on_h[i], bus.wdat, bus.sel);
						`PIT_REG_CTL: begin
							// flags and commit bit share byte 0
							if (bus.sel[0]) begin
								ctl_h[i] <= bus.wdat[4:0];
								commit_q[i] <= bus.wdat[`PIT_CTL_COMMIT];
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// ============================================================
	// read mux and interrupt
	// ============================================================

	always_comb begin
		pit_pkg::ctl_t rd_ctl;
		rd_ctl = ctl_act_v[chan];
		// load is a one-shot request and never reads back
		rd_ctl[`PIT_CTL_LD] = 1'b0;
		bus.rdat = '0;
		if (chan_hit) begin
			case (offs)
				`PIT_REG_COUNT: bus.rdat = count_v[chan];
				`PIT_REG_MAX: bus.rdat = max_h[chan];
				`PIT_REG_ON: bus.rdat = on_h[chan];
				`PIT_REG_CTL: bus.rdat = pit_pkg::dat_t'(rd_ctl);
				default: bus.rdat = '0;
			endcase
		end else begin
			case (bus.adr)
				`PIT_REG_UF: bus.rdat = pit_pkg::dat_t'(underflow);
				`PIT_REG_IE: bus.rdat = pit_pkg::dat_t'(ie);
				`PIT_REG_OUT: bus.rdat = pit_pkg::dat_t'(out_v);
				// sync is write-only, unmapped words read 0
				default: bus.rdat = '0;
			endcase
		end
	end

	// latched underflow gated by the enable mask
	assign irq_o = |(underflow & ie);

endmodule

// ==== hw/pit_wb_slave.sv ====
`timescale 1ns/1ps

module pit_wb_slave (
	input logic clk,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input pit_pkg::adr_t wb_adr_i,
	input pit_pkg::dat_t wb_dat_i,
	input pit_pkg::sel_t wb_sel_i,
	output pit_pkg::dat_t wb_dat_o,
	output logic wb_ack_o,
	pit_bus_if.slave bus
);

	pit_pkg::wb_state_t state;
	logic req;

	// a new access is only taken in IDLE, so each strobe gives one req
	assign req = (state == pit_pkg::IDLE) && wb_cyc_i && wb_stb_i;

	// address and data are stable while the master waits for ack
	assign bus.req = req;
	assign bus.we = wb_we_i;
	assign bus.adr = wb_adr_i;
	assign bus.wdat = wb_dat_i;
	assign bus.sel = wb_sel_i;

	// ack is high for the whole ACK state, which lasts one cycle
	assign wb_ack_o = (state == pit_pkg::ACK);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= pit_pkg::IDLE;
			wb_dat_o <= '0;
		end else begin
			case (state)
				pit_pkg::IDLE: begin
					// capture read data together with the access
					if (req) begin
						wb_dat_o <= bus.rdat;
						state <= pit_pkg::ACK;
					end
				end
				pit_pkg::ACK: begin
					// master drops stb after ack
					state <= pit_pkg::IDLE;
				end
				default: state <= pit_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== hw/pit_tmr_if.sv ====
`timescale 1ns/1ps

// settings down to one counter channel, status back up
interface pit_tmr_if;

	// one-cycle pulse, copy holding values into the active state
	logic commit;
	// holding values waiting for a commit
	pit_pkg::cnt_t max_h;
	pit_pkg::cnt_t on_h;
	pit_pkg::ctl_t ctl_h;
	// live channel status
	pit_pkg::cnt_t count;
	pit_pkg::ctl_t ctl_act;
	logic out;
	// one-cycle pulse at terminal count
	logic uf;

	// register bank side
	modport regs (
		output commit,
		output max_h,
		output on_h,
		output ctl_h,
		input count,
		input ctl_act,
		input out,
		input uf
	);

	// counter side
	modport timer (
		input commit,
		input max_h,
		input on_h,
		input ctl_h,
		output count,
		output ctl_act,
		output out,
		output uf
	);

endinterface

// ==== hw/pit_bus_if.sv ====
`timescale 1ns/1ps

// one decoded register access, bus slave to register bank
interface pit_bus_if;

	// single-cycle access strobe
	logic req;
	// write when high, read otherwise
	logic we;
	// word address of the access
	pit_pkg::adr_t adr;
	// write data and its byte lanes
	pit_pkg::dat_t wdat;
	pit_pkg::sel_t sel;
	// read data, combinational from adr
	pit_pkg::dat_t rdat;

	// bus slave side
	modport slave (
		output req,
		output we,
		output adr,
		output wdat,
		output sel,
		input rdat
	);

	// register bank side
	modport regs (
		input req,
		input we,
		input adr,
		input wdat,
		input sel,
		output rdat
	);

endinterface

// ==== hw/pit_pkg.sv ====
`include "pit_defs.svh"

package pit_pkg;

	// ============================================================
	// data types
	// ============================================================

	// one counter value
	typedef logic [`PIT_CNT_W-1:0] cnt_t;

	// register word address as seen on the bus
	typedef logic [7:0] adr_t;

	// bus data word and its byte selects
	typedef logic [31:0] dat_t;
	typedef logic [3:0] sel_t;

	// channel flags, indexed by the PIT_CTL_* bit positions
	// ld, ce, ar, xc, ge from bit 0 upward
	typedef logic [4:0] ctl_t;

	// one bit per channel
	typedef logic [`PIT_NTIMER-1:0] tmask_t;

	// ============================================================
	// bus slave FSM
	// ============================================================

	// IDLE waits for a strobe, ACK answers it for one cycle
	typedef enum logic [0:0] {
		IDLE = 1'b0,
		ACK = 1'b1
	} wb_state_t;

endpackage

// ==== hw/pit_defs.svh ====
`ifndef PIT_DEFS_SVH
`define PIT_DEFS_SVH

// ============================================================
// timer geometry
// ============================================================

// number of timer channels, fixed by the register map
`define PIT_NTIMER 4
// counter width in bits
`define PIT_CNT_W 32

// ============================================================
// register map, word addresses
// ============================================================

// word offsets inside a channel block, channel n starts at word n*4
`define PIT_REG_COUNT 2'd0
`define PIT_REG_MAX 2'd1
`define PIT_REG_ON 2'd2
`define PIT_REG_CTL 2'd3

// global registers above the channel blocks
`define PIT_REG_UF 8'h40
`define PIT_REG_SYNC 8'h41
`define PIT_REG_IE 8'h42
`define PIT_REG_OUT 8'h43

// control word bit positions
`define PIT_CTL_LD 0
`define PIT_CTL_CE 1
`define PIT_CTL_AR 2
`define PIT_CTL_XC 3
`define PIT_CTL_GE 4
`define PIT_CTL_COMMIT 7

`endif
